// File: Makefile
TOP := eth_receive_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: common/eth_pkg.sv
package eth_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Framing bytes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hd5;

    // Exactly this many 0x55 bytes before the SFD
    localparam int preamble_len = 7;

    localparam int mac_bytes = 6;

    ////////////////////////////////////////////////////////////////////////////
    // Station address
    ////////////////////////////////////////////////////////////////////////////

    // 00:0A:35:01:FE:C0, first byte on the wire in the top bits
    localparam logic [47:0] board_mac = 48'h000a_3501_fec0;

endpackage

// File: common/frame_if.sv
`timescale 1ns/1ps

interface frame_if;

    // Header fields, held from hdr_valid until the next frame
    rx_pkg::mac_t  dest_mac;
    rx_pkg::mac_t  src_mac;
    logic          hdr_valid;

    // Payload strobe and byte
    rx_pkg::byte_t data;
    logic          data_valid;
    logic          frame_end;

    modport parser (
        output dest_mac, src_mac, hdr_valid, data, data_valid, frame_end
    );

    modport filter (
        input dest_mac, src_mac, hdr_valid, data, data_valid, frame_end
    );

endinterface

// File: common/rx_pkg.sv
package rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [47:0] mac_t;

    // Counts bytes inside the preamble or one address field
    typedef logic [2:0] count_t;

    // Parser states
    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_sfd,
        st_dest,
        st_src,
        st_payload,
        st_drain
    } parse_state_e;

endpackage

// File: design/eth_receive_top.sv
`timescale 1ns/1ps

module eth_receive_top
(
    input  logic            phy_rx_clk,
    input  logic            reset,
    input  rx_pkg::nibble_t phy_rxd,
    input  logic            phy_rx_ctrl,
    output rx_pkg::byte_t   rx_data,
    output logic            data_valid,
    output logic            frame_done,
    output rx_pkg::mac_t    src_mac
);

    rx_pkg::byte_t byte_data;
    logic          byte_strobe;
    logic          frame_active;

    frame_if frm ();

    nibble_assembler nibble_assembler_inst (
        .phy_rx_clk   (phy_rx_clk),
        .reset        (reset),
        .phy_rxd      (phy_rxd),
        .phy_rx_ctrl  (phy_rx_ctrl),
        .byte_data    (byte_data),
        .byte_strobe  (byte_strobe),
        .frame_active (frame_active)
    );

    frame_parser frame_parser_inst (
        .phy_rx_clk   (phy_rx_clk),
        .reset        (reset),
        .byte_data    (byte_data),
        .byte_strobe  (byte_strobe),
        .frame_active (frame_active),
        .frm          (frm)
    );

    mac_filter mac_filter_inst (
        .phy_rx_clk (phy_rx_clk),
        .reset      (reset),
        .frm        (frm),
        .rx_data    (rx_data),
        .data_valid (data_valid),
        .frame_done (frame_done),
        .src_mac    (src_mac)
    );

endmodule

// File: design/mac_filter.sv
`timescale 1ns/1ps

module mac_filter
(
    input  logic          phy_rx_clk,
    input  logic          reset,
    frame_if.filter       frm,
    output rx_pkg::byte_t rx_data,
    output logic          data_valid,
    output logic          frame_done,
    output rx_pkg::mac_t  src_mac
);

    logic matched;
    logic dest_hit;

    assign dest_hit = (frm.dest_mac == eth_pkg::board_mac);

    ////////////////////////////////////////////////////////////////////////////
    // Match flag and output strobes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            matched    <= 1'b0;
            data_valid <= 1'b0;
            frame_done <= 1'b0;
            src_mac    <= '0;
        end
        else
        begin
            data_valid <= frm.data_valid & matched;
            frame_done <= frm.frame_end & matched;
            if (frm.hdr_valid)
            begin
                matched <= dest_hit;
                // Sender of the last accepted frame
                if (dest_hit)
                    src_mac <= frm.src_mac;
            end
            else if (frm.frame_end)
                matched <= 1'b0;
        end
    end

    always_ff @(posedge phy_rx_clk)
    begin
        if (frm.data_valid && matched)
            rx_data <= frm.data;
    end

endmodule

// File: design/nibble_assembler.sv
`timescale 1ns/1ps

module nibble_assembler
(
    input  logic            phy_rx_clk,
    input  logic            reset,
    input  rx_pkg::nibble_t phy_rxd,
    input  logic            phy_rx_ctrl,
    output rx_pkg::byte_t   byte_data,
    output logic            byte_strobe,
    output logic            frame_active
);

    rx_pkg::nibble_t rxd_q;
    rx_pkg::nibble_t low_nibble;
    logic            ctrl_q;
    logic            phase;

    // Phase restarts whenever the PHY drops ctrl
    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            ctrl_q       <= 1'b0;
            phase        <= 1'b0;
            byte_strobe  <= 1'b0;
            frame_active <= 1'b0;
        end
        else
        begin
            ctrl_q       <= phy_rx_ctrl;
            frame_active <= ctrl_q;
            byte_strobe  <= ctrl_q & phase;
            if (ctrl_q)
                phase <= ~phase;
            else
                phase <= 1'b0;
        end
    end

    // Low nibble arrives first
    always_ff @(posedge phy_rx_clk)
    begin
        rxd_q <= phy_rxd;
        if (ctrl_q && !phase)
            low_nibble <= rxd_q;
        if (ctrl_q && phase)
            byte_data <= {rxd_q, low_nibble};
    end

endmodule

// File: frame_parser/frame_parser.sv
`timescale 1ns/1ps

module frame_parser
(
    input  logic           phy_rx_clk,
    input  logic           reset,
    input  rx_pkg::byte_t  byte_data,
    input  logic           byte_strobe,
    input  logic           frame_active,
    frame_if.parser        frm
);

    rx_pkg::parse_state_e state;
    rx_pkg::count_t       count;

    localparam rx_pkg::count_t last_preamble = rx_pkg::count_t'(eth_pkg::preamble_len - 1);
    localparam rx_pkg::count_t last_mac_byte = rx_pkg::count_t'(eth_pkg::mac_bytes - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Frame state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
        begin
            state          <= rx_pkg::st_idle;
            count          <= '0;
            frm.hdr_valid  <= 1'b0;
            frm.data_valid <= 1'b0;
            frm.frame_end  <= 1'b0;
        end
        else
        begin
            frm.hdr_valid  <= 1'b0;
            frm.data_valid <= 1'b0;
            frm.frame_end  <= 1'b0;
            if (!frame_active)
            begin
                // Only a frame that reached its payload ends cleanly
                if (state == rx_pkg::st_payload)
                    frm.frame_end <= 1'b1;
                state <= rx_pkg::st_idle;
                count <= '0;
            end
            else if (byte_strobe)
            begin
                case (state)
                    rx_pkg::st_idle:
                    begin
                        if (byte_data == eth_pkg::preamble_byte)
                            state <= rx_pkg::st_preamble;
                        else
                            state <= rx_pkg::st_drain;
                        count <= rx_pkg::count_t'(1);
                    end
                    rx_pkg::st_preamble:
                    begin
                        if (byte_data != eth_pkg::preamble_byte)
                            state <= rx_pkg::st_drain;
                        else if (count == last_preamble)
                            state <= rx_pkg::st_sfd;
                        else
                            count <= count + 1'b1;
                    end
                    rx_pkg::st_sfd:
                    begin
                        // An eighth 0x55 also lands here and is rejected
                        if (byte_data == eth_pkg::sfd_byte)
                            state <= rx_pkg::st_dest;
                        else
                            state <= rx_pkg::st_drain;
                        count <= '0;
                    end
                    rx_pkg::st_dest:
                    begin
                        if (count == last_mac_byte)
                        begin
                            state <= rx_pkg::st_src;
                            count <= '0;
                        end
                        else
                            count <= count + 1'b1;
                    end
                    rx_pkg::st_src:
                    begin
                        if (count == last_mac_byte)
                        begin
                            state         <= rx_pkg::st_payload;
                            count         <= '0;
                            frm.hdr_valid <= 1'b1;
                        end
                        else
                            count <= count + 1'b1;
                    end
                    rx_pkg::st_payload:
                        frm.data_valid <= 1'b1;
                    default:
                        state <= rx_pkg::st_drain;
                endcase
            end
        end
    end

    // Header shift registers and payload byte
    always_ff @(posedge phy_rx_clk)
    begin
        if (byte_strobe && frame_active)
        begin
            if (state == rx_pkg::st_dest)
                frm.dest_mac <= {frm.dest_mac[39:0], byte_data};
            if (state == rx_pkg::st_src)
                frm.src_mac <= {frm.src_mac[39:0], byte_data};
            if (state == rx_pkg::st_payload)
                frm.data <= byte_data;
        end
    end

endmodule

// File: verif/eth_receive_sva.sv
`timescale 1ns/1ps

module eth_receive_sva
#(
    parameter bit check_state = 1'b1
)
(
    input logic                 phy_rx_clk,
    input logic                 reset,
    input rx_pkg::parse_state_e state,
    input logic                 hdr_valid,
    input logic                 data_valid,
    input logic                 frame_done
);

    logic seen_data;

    // Payload seen since the last header
    always_ff @(posedge phy_rx_clk or posedge reset)
    begin
        if (reset)
            seen_data <= 1'b0;
        else if (hdr_valid)
            seen_data <= 1'b0;
        else if (data_valid)
            seen_data <= 1'b1;
    end

    no_overlap: assert property (@(posedge phy_rx_clk) disable iff (reset)
        !(data_valid && frame_done))
        else $error("data_valid and frame_done high in the same cycle");

    done_after_data: assert property (@(posedge phy_rx_clk) disable iff (reset)
        frame_done |-> seen_data)
        else $error("frame_done without any payload byte since the header");

    // Only the parser has a state to look at
    generate
        if (check_state)
        begin : g_state
            idle_after_reset: assert property (@(posedge phy_rx_clk)
                $fell(reset) |=> state == rx_pkg::st_idle)
                else $error("parser not idle one cycle after reset release");
        end
    endgenerate

endmodule

bind frame_parser eth_receive_sva parser_sva (
    .phy_rx_clk (phy_rx_clk),
    .reset      (reset),
    .state      (state),
    .hdr_valid  (frm.hdr_valid),
    .data_valid (frm.data_valid),
    .frame_done (frm.frame_end)
);

bind mac_filter eth_receive_sva #(.check_state(1'b0)) filter_sva (
    .phy_rx_clk (phy_rx_clk),
    .reset      (reset),
    .state      (rx_pkg::st_idle),
    .hdr_valid  (frm.hdr_valid),
    .data_valid (data_valid),
    .frame_done (frame_done)
);

// File: verif/eth_receive_tb.sv
`timescale 1ns/1ps

module eth_receive_tb;

    localparam int num_rows = 12;
    localparam int hdr_len  = eth_pkg::preamble_len + 1 + 2 * eth_pkg::mac_bytes;

    logic            phy_rx_clk;
    logic            reset;
    rx_pkg::nibble_t phy_rxd;
    logic            phy_rx_ctrl;
    rx_pkg::byte_t   rx_data;
    logic            data_valid;
    logic            frame_done;
    rx_pkg::mac_t    src_mac;

    // Frame table, one entry per row in each column
    int            pre_count [num_rows];
    rx_pkg::byte_t sfd       [num_rows];
    rx_pkg::mac_t  dest      [num_rows];
    rx_pkg::mac_t  src       [num_rows];
    int            pay_len   [num_rows];
    int            cut_after [num_rows];   // 0 means no cut

    rx_pkg::byte_t tx_bytes [$];
    rx_pkg::byte_t exp_bytes [$];
    rx_pkg::byte_t got_bytes [$];
    rx_pkg::mac_t  exp_src;
    logic          accept;
    int            done_count;
    int            errors;
    int            watchdog_ns;

    eth_receive_top eth_receive_top_inst (
        .phy_rx_clk  (phy_rx_clk),
        .reset       (reset),
        .phy_rxd     (phy_rxd),
        .phy_rx_ctrl (phy_rx_ctrl),
        .rx_data     (rx_data),
        .data_valid  (data_valid),
        .frame_done  (frame_done),
        .src_mac     (src_mac)
    );

    always #5 phy_rx_clk = ~phy_rx_clk;

    // Output monitor, sampled on the falling edge
    always @(negedge phy_rx_clk)
    begin
        if (data_valid)
            got_bytes.push_back(rx_data);
        if (frame_done)
            done_count++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame table
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_row(input int i, input int pre, input rx_pkg::byte_t s,
                           input rx_pkg::mac_t d, input rx_pkg::mac_t a,
                           input int len, input int cut);
        pre_count[i] = pre;
        sfd[i]       = s;
        dest[i]      = d;
        src[i]       = a;
        pay_len[i]   = len;
        cut_after[i] = cut;
    endtask

    task automatic fill_table();
        set_row(0,  7, 8'hd5, eth_pkg::board_mac, 48'h0012_3456_789a, 16, 0);
        set_row(1,  7, 8'hd5, 48'h0000_5e00_0101, 48'h0012_3456_789b, 10, 0);
        set_row(2,  6, 8'hd5, eth_pkg::board_mac, 48'h0012_3456_789c, 8, 0);
        set_row(3,  8, 8'hd5, eth_pkg::board_mac, 48'h0012_3456_789d, 8, 0);
        set_row(4,  7, 8'hd4, eth_pkg::board_mac, 48'h0012_3456_789e, 8, 0);
        // Cut inside the destination field
        set_row(5,  7, 8'hd5, eth_pkg::board_mac, 48'h0012_3456_789f, 8, 11);
        set_row(6,  7, 8'hd5, eth_pkg::board_mac, 48'h02aa_bbcc_dd01, 1, 0);
        // Alternating matched and unmatched
        set_row(7,  7, 8'hd5, eth_pkg::board_mac, 48'h02aa_bbcc_dd02, 5, 0);
        set_row(8,  7, 8'hd5, 48'h000a_3501_fec1, 48'h02aa_bbcc_dd03, 8, 0);
        set_row(9,  7, 8'hd5, eth_pkg::board_mac, 48'h02aa_bbcc_dd04, 20, 0);
        set_row(10, 7, 8'hd5, 48'hffff_ffff_ffff, 48'h02aa_bbcc_dd05, 3, 0);
        set_row(11, 7, 8'hd5, eth_pkg::board_mac, 48'h02aa_bbcc_dd06, 4, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_frame(input int i);
        tx_bytes.delete();
        exp_bytes.delete();
        repeat (pre_count[i])
            tx_bytes.push_back(eth_pkg::preamble_byte);
        tx_bytes.push_back(sfd[i]);
        // Address bytes go out first byte first, top bits of the field
        for (int k = 5; k >= 0; k--)
            tx_bytes.push_back(dest[i][k*8 +: 8]);
        for (int k = 5; k >= 0; k--)
            tx_bytes.push_back(src[i][k*8 +: 8]);
        for (int k = 0; k < pay_len[i]; k++)
            tx_bytes.push_back(rx_pkg::byte_t'($urandom));
        while (cut_after[i] > 0 && tx_bytes.size() > cut_after[i])
            void'(tx_bytes.pop_back());
        accept = pre_count[i] == eth_pkg::preamble_len && sfd[i] == eth_pkg::sfd_byte
                 && dest[i] == eth_pkg::board_mac && tx_bytes.size() > hdr_len;
        if (accept)
            for (int k = hdr_len; k < tx_bytes.size(); k++)
                exp_bytes.push_back(tx_bytes[k]);
    endtask

    task automatic drive_frame();
        foreach (tx_bytes[k])
        begin
            @(posedge phy_rx_clk);
            phy_rxd     <= tx_bytes[k][3:0];
            phy_rx_ctrl <= 1'b1;
            @(posedge phy_rx_clk);
            phy_rxd     <= tx_bytes[k][7:4];
        end
        @(posedge phy_rx_clk);
        phy_rx_ctrl <= 1'b0;
        phy_rxd     <= '0;
    endtask

    task automatic wait_frame_end(input int i);
        int n;
        n = 0;
        while (accept && done_count == 0 && n < 20)
        begin
            @(posedge phy_rx_clk);
            n++;
        end
        assert (!accept || done_count > 0)
        else
        begin
            $display("frame %0d: frame_done did not arrive in time", i);
            errors++;
        end
        // Short idle gap, also catches late or extra pulses
        repeat (6) @(posedge phy_rx_clk);
    endtask

    task automatic check_frame(input int i);
        assert (got_bytes.size() == exp_bytes.size())
        else
        begin
            $display("[ERROR] frame %0d data_valid count: got %h expected %h",
                     i, got_bytes.size(), exp_bytes.size());
            errors++;
        end
        foreach (exp_bytes[k])
        begin
            if (k < got_bytes.size())
            begin
                assert (got_bytes[k] == exp_bytes[k])
                else
                begin
                    $display("[ERROR] frame %0d rx_data byte %0d: got %h expected %h",
                             i, k, got_bytes[k], exp_bytes[k]);
                    errors++;
                end
            end
        end
        assert (done_count == (accept ? 1 : 0))
        else
        begin
            $display("frame %0d: expected %0d frame_done pulses but saw %0d",
                     i, accept ? 1 : 0, done_count);
            errors++;
        end
        assert (src_mac == exp_src)
        else
        begin
            $display("[ERROR] frame %0d src_mac: got %h expected %h", i, src_mac, exp_src);
            errors++;
        end
    endtask

    function automatic int run_time_ns();
        int total;
        total = 1000;
        for (int i = 0; i < num_rows; i++)
            total += 2 * (pre_count[i] + 13 + pay_len[i]) * 10 + 400;
        return total;
    endfunction

    initial
    begin
        phy_rx_clk  = 1'b0;
        reset       = 1'b1;
        phy_rxd     = '0;
        phy_rx_ctrl = 1'b0;
        errors      = 0;
        done_count  = 0;
        exp_src     = '0;
        void'($urandom(32'h8f83));
        fill_table();
        watchdog_ns = run_time_ns();
        repeat (8) @(posedge phy_rx_clk);
        reset <= 1'b0;
        repeat (4) @(posedge phy_rx_clk);
        for (int i = 0; i < num_rows; i++)
        begin
            got_bytes.delete();
            done_count = 0;
            build_frame(i);
            drive_frame();
            wait_frame_end(i);
            if (accept)
                exp_src = src[i];
            check_frame(i);
        end
        $display("frames: %0d, errors: %0d", num_rows, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, simulation stopped", watchdog_ns);
        $display("tests failed");
        $finish;
    end

endmodule

// File: vlog.f
common/eth_pkg.sv
common/rx_pkg.sv
common/frame_if.sv
design/nibble_assembler.sv
frame_parser/frame_parser.sv
design/mac_filter.sv
design/eth_receive_top.sv
verif/eth_receive_sva.sv
verif/eth_receive_tb.sv
